//--- sim.f
common/dtm_pkg.sv
common/tap_ctrl_if.sv
tap/tap_controller.sv
hdl/dr_shifter.sv
dmi/dmi_bridge.sv
hdl/dtm_jtag_top.sv
verif/dtm_jtag_sva.sv
verif/tb_dtm_jtag.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DTM testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_dtm_jtag -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_dtm_jtag > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- verif/tb_dtm_jtag.sv
/*
 * testbench for the JTAG debug transport module
 * JTAG driver tasks, a small DM model with memory, directed tests
 */
`timescale 1ns/1ps

module tb_dtm_jtag;

    localparam dtm_pkg::dtm_reg_t TB_IDCODE    = 32'h0DB5A1C3;
    localparam logic [2:0]        TB_IDLE_HINT = 3'd4;
    // wait limit in cycles is above the longest DM delay
    localparam int                WAIT_LIMIT   = 200;

    logic               jtag_TCK        = 1'b0;
    logic               nrst_i          = 1'b0;
    logic               jtag_tdi_i      = 1'b0;
    logic               jtag_tms_i      = 1'b1;
    logic               jtag_tdo_o;
    logic               dtm_req_valid_o;
    dtm_pkg::dmi_word_t dtm_req_data_o;
    logic               dm_req_ack_i    = 1'b1;
    logic               dm_resp_valid_i = 1'b0;
    dtm_pkg::dmi_word_t dm_resp_data_i  = '0;
    logic               dtm_resp_ack_o;

    // DM model state
    dtm_pkg::dmi_data_t mem [32];
    dtm_pkg::dmi_word_t last_req     = '0;
    dtm_pkg::dmi_word_t pending_word = '0;
    logic               resp_pending = 1'b0;
    int                 resp_wait    = 0;
    int                 dm_delay     = 2;
    int                 req_count    = 0;
    int                 resp_count   = 0;

    int seed          = 18330;
    int check_count   = 0;
    int error_count   = 0;
    int timeout_count = 0;

    dtm_jtag_top #(
        .IDCODE    (TB_IDCODE),
        .IDLE_HINT (TB_IDLE_HINT)
    ) dtm_jtag_top_i (
        .jtag_TCK        (jtag_TCK),
        .nrst_i          (nrst_i),
        .jtag_tdi_i      (jtag_tdi_i),
        .jtag_tms_i      (jtag_tms_i),
        .jtag_tdo_o      (jtag_tdo_o),
        .dtm_req_valid_o (dtm_req_valid_o),
        .dtm_req_data_o  (dtm_req_data_o),
        .dm_req_ack_i    (dm_req_ack_i),
        .dm_resp_valid_i (dm_resp_valid_i),
        .dm_resp_data_i  (dm_resp_data_i),
        .dtm_resp_ack_o  (dtm_resp_ack_o)
    );

    // 100 ns TCK
    always #50 jtag_TCK = ~jtag_TCK;

    // ==================================================
    // expected values and checks
    // ==================================================
    function automatic dtm_pkg::dmi_word_t make_word(input dtm_pkg::dmi_addr_t addr,
                                                     input dtm_pkg::dmi_data_t data,
                                                     input dtm_pkg::dmi_op_t op);
        return {addr, data, op};
    endfunction

    // version 1, abits 5, idle hint, dmistat
    function automatic dtm_pkg::dtm_reg_t make_dtmcs(input dtm_pkg::dmi_op_t stat);
        return {17'b0, TB_IDLE_HINT, stat, 6'd5, 4'd1};
    endfunction

    task automatic check_reg(input string what, input dtm_pkg::dtm_reg_t got,
                             input dtm_pkg::dtm_reg_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_word(input string what, input dtm_pkg::dmi_word_t got,
                              input dtm_pkg::dmi_word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_op(input string what, input dtm_pkg::dmi_op_t got,
                            input dtm_pkg::dmi_op_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("Error at %0t: %s, got %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // ==================================================
    // JTAG driver
    // ==================================================
    // drive on the falling edge and sample TDO at the rising edge
    task automatic clock_bit(input logic tms, input logic tdi, output logic tdo);
        @(negedge jtag_TCK);
        jtag_tms_i = tms;
        jtag_tdi_i = tdi;
        @(posedge jtag_TCK);
        tdo = jtag_tdo_o;
    endtask

    // TMS path with bit 0 first
    task automatic drive_tms(input logic [7:0] path, input int n);
        logic unused_tdo;
        for (int i = 0; i < n; i++) begin
            clock_bit(path[i], 1'b0, unused_tdo);
        end
    endtask

    // idle to idle through shift-ir
    task automatic ir_scan(input dtm_pkg::ir_t code);
        logic unused_tdo;
        drive_tms(8'b0011, 4);
        for (int i = 0; i < dtm_pkg::IR_W; i++) begin
            clock_bit(i == dtm_pkg::IR_W - 1, code[i], unused_tdo);
        end
        drive_tms(8'b01, 2);
    endtask

    // idle to idle through shift-dr and return the TDO bits
    task automatic dr_scan(input int len, input dtm_pkg::dmi_word_t tdi_word,
                           output dtm_pkg::dmi_word_t tdo_word);
        logic tdo_bit;
        tdo_word = '0;
        drive_tms(8'b001, 3);
        for (int i = 0; i < len; i++) begin
            clock_bit(i == len - 1, tdi_word[i], tdo_bit);
            tdo_word[i] = tdo_bit;
        end
        drive_tms(8'b01, 2);
    endtask

    // ==================================================
    // DM model
    // ==================================================
    // a read returns memory and a write stores the data
    // both answer with op 0
    task automatic serve_request(input dtm_pkg::dmi_word_t req,
                                 output dtm_pkg::dmi_word_t resp);
        dtm_pkg::dmi_addr_t addr;
        dtm_pkg::dmi_data_t data;
        addr = req[38:34];
        data = req[33:2];
        if (req[1:0] == dtm_pkg::DMI_OP_WRITE) begin
            mem[addr] = data;
        end else if (req[1:0] == dtm_pkg::DMI_OP_READ) begin
            data = mem[addr];
        end
        resp = make_word(addr, data, dtm_pkg::DMI_OP_NOP);
    endtask

    always @(negedge jtag_TCK) begin
        dm_resp_valid_i = 1'b0;
        if (resp_pending) begin
            if (resp_wait == 0) begin
                dm_resp_valid_i = 1'b1;
                dm_resp_data_i  = pending_word;
                resp_pending    = 1'b0;
                resp_count++;
            end else begin
                resp_wait--;
            end
        end
        if (nrst_i && dtm_req_valid_o) begin
            last_req = dtm_req_data_o;
            req_count++;
            serve_request(dtm_req_data_o, pending_word);
            resp_pending = 1'b1;
            resp_wait    = dm_delay;
        end
    end

    // the DTM takes each response in the cycle it is offered and acks nothing else
    always @(posedge jtag_TCK) begin
        if (nrst_i && (dm_resp_valid_i || dtm_resp_ack_o !== 1'b0)) begin
            check_bit("response ack", dtm_resp_ack_o, dm_resp_valid_i);
        end
    end

    task automatic wait_for_request(input int target);
        int cycles;
        cycles = 0;
        while (req_count < target && cycles < WAIT_LIMIT) begin
            @(posedge jtag_TCK);
            cycles++;
        end
        if (req_count < target) begin
            $display("timeout: DM request %0d never arrived", target);
            timeout_count++;
        end
    endtask

    task automatic wait_for_response(input int target);
        int cycles;
        cycles = 0;
        while (resp_count < target && cycles < WAIT_LIMIT) begin
            @(posedge jtag_TCK);
            cycles++;
        end
        if (resp_count < target) begin
            $display("timeout: DM response %0d was never sent", target);
            timeout_count++;
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_idcode();
        dtm_pkg::dmi_word_t tdo;
        dr_scan(32, '0, tdo);
        check_reg("idcode after reset", tdo[31:0], TB_IDCODE);
        // move IR away and let five TMS high clocks reset the TAP
        ir_scan(dtm_pkg::IR_DTMCS);
        drive_tms(8'h1f, 5);
        drive_tms(8'h00, 1);
        dr_scan(32, '0, tdo);
        check_reg("idcode after TMS reset", tdo[31:0], TB_IDCODE);
    endtask

    task automatic test_dtmcs();
        dtm_pkg::dmi_word_t tdo;
        ir_scan(dtm_pkg::IR_DTMCS);
        dr_scan(32, '0, tdo);
        check_reg("dtmcs idle", tdo[31:0], make_dtmcs(dtm_pkg::DMI_OP_NOP));
        check_op("dtmcs dmistat idle", tdo[11:10], dtm_pkg::DMI_OP_NOP);
    endtask

    // one bit delay for bypass, zero and unimplemented codes
    task automatic test_bypass();
        dtm_pkg::ir_t       codes [3];
        dtm_pkg::dmi_word_t tdo;
        dtm_pkg::dtm_reg_t  pattern;
        codes[0] = dtm_pkg::IR_BYPASS;
        codes[1] = 5'h00;
        codes[2] = 5'h05;
        for (int i = 0; i < 3; i++) begin
            ir_scan(codes[i]);
            pattern = $random(seed);
            dr_scan(32, {7'b0, pattern}, tdo);
            check_reg($sformatf("bypass through IR %h", codes[i]), tdo[31:0],
                      {pattern[30:0], 1'b0});
        end
    endtask

    task automatic test_dmi_access();
        dtm_pkg::dmi_word_t tdo;
        dtm_pkg::dmi_data_t wdata;
        int                 base;
        int                 rbase;
        dm_delay = 2;
        base     = req_count;
        rbase    = resp_count;
        wdata    = $random(seed);
        ir_scan(dtm_pkg::IR_DMI);
        dr_scan(39, make_word(5'd3, wdata, dtm_pkg::DMI_OP_WRITE), tdo);
        wait_for_request(base + 1);
        check_word("write request", last_req, make_word(5'd3, wdata, dtm_pkg::DMI_OP_WRITE));
        wait_for_response(rbase + 1);
        dr_scan(39, make_word(5'd3, '0, dtm_pkg::DMI_OP_READ), tdo);
        check_word("write response", tdo, make_word(5'd3, wdata, dtm_pkg::DMI_OP_NOP));
        wait_for_request(base + 2);
        check_word("read request", last_req, make_word(5'd3, '0, dtm_pkg::DMI_OP_READ));
        wait_for_response(rbase + 2);
        dr_scan(39, make_word(5'd0, '0, dtm_pkg::DMI_OP_NOP), tdo);
        check_word("read response", tdo, make_word(5'd3, wdata, dtm_pkg::DMI_OP_NOP));
        wait_for_request(base + 3);
        wait_for_response(rbase + 3);
        check_reg("requests per scan", 32'(req_count), 32'(base + 3));
    endtask

    task automatic test_sticky_busy();
        dtm_pkg::dmi_word_t tdo;
        dtm_pkg::dmi_word_t reset_word;
        dtm_pkg::dmi_data_t wdata;
        int                 base;
        int                 rbase;
        dm_delay   = 80;
        base       = req_count;
        rbase      = resp_count;
        wdata      = $random(seed);
        reset_word = '0;
        reset_word[dtm_pkg::DTMCS_DMIRESET_BIT] = 1'b1;
        ir_scan(dtm_pkg::IR_DMI);
        dr_scan(39, make_word(5'd7, wdata, dtm_pkg::DMI_OP_WRITE), tdo);
        wait_for_request(base + 1);
        // second scan lands while the DM is still working
        dr_scan(39, make_word(5'd7, ~wdata, dtm_pkg::DMI_OP_WRITE), tdo);
        check_word("scan while busy", tdo, make_word(5'd0, '0, dtm_pkg::DMI_OP_BUSY));
        wait_for_response(rbase + 1);
        dr_scan(39, make_word(5'd0, '0, dtm_pkg::DMI_OP_NOP), tdo);
        check_op("sticky busy op", tdo[1:0], dtm_pkg::DMI_OP_BUSY);
        repeat (2) @(posedge jtag_TCK);
        check_reg("requests while busy", 32'(req_count), 32'(base + 1));
        ir_scan(dtm_pkg::IR_DTMCS);
        dr_scan(32, '0, tdo);
        check_op("dtmcs dmistat busy", tdo[11:10], dtm_pkg::DMI_OP_BUSY);
        dr_scan(32, reset_word, tdo);
        dr_scan(32, '0, tdo);
        check_reg("dtmcs after dmireset", tdo[31:0], make_dtmcs(dtm_pkg::DMI_OP_NOP));
        // repeat the dropped write
        ir_scan(dtm_pkg::IR_DMI);
        dm_delay = 2;
        dr_scan(39, make_word(5'd7, ~wdata, dtm_pkg::DMI_OP_WRITE), tdo);
        check_word("response after dmireset", tdo, make_word(5'd7, wdata, dtm_pkg::DMI_OP_NOP));
        wait_for_request(base + 2);
        check_word("repeated request", last_req,
                   make_word(5'd7, ~wdata, dtm_pkg::DMI_OP_WRITE));
        wait_for_response(rbase + 2);
        dr_scan(39, make_word(5'd0, '0, dtm_pkg::DMI_OP_NOP), tdo);
        check_word("repeated response", tdo, make_word(5'd7, ~wdata, dtm_pkg::DMI_OP_NOP));
        wait_for_request(base + 3);
        wait_for_response(rbase + 3);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        // DM memory fill with a different word for every address
        for (int a = 0; a < 32; a++) begin
            mem[a] = 32'hA000_0000 ^ (32'(a) * 32'h0101_0101);
        end
        repeat (4) @(posedge jtag_TCK);
        @(negedge jtag_TCK);
        nrst_i = 1'b1;
        // test-logic-reset to run-test-idle
        drive_tms(8'h00, 1);
        test_idcode();
        test_dtmcs();
        test_bypass();
        test_dmi_access();
        test_sticky_busy();
        repeat (4) @(posedge jtag_TCK);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/dtm_jtag_sva.sv
/*
 * DTM protocol assertions
 * bound to the top level, checks the DM request handshake and the TDO idle level
 */
`timescale 1ns/1ps

module dtm_jtag_sva (
    input logic jtag_TCK,
    input logic nrst_i,
    input logic shift_dr_i,
    input logic shift_ir_i,
    input logic tdo_i,
    input logic req_valid_i,
    input logic resp_valid_i
);

    logic outstanding_q;

    // a request stays in flight until the DM answers
    always_ff @(posedge jtag_TCK or negedge nrst_i) begin
        if (!nrst_i) begin
            outstanding_q <= 1'b0;
        end else if (resp_valid_i) begin
            outstanding_q <= 1'b0;
        end else if (req_valid_i) begin
            outstanding_q <= 1'b1;
        end
    end

    valid_one_cycle: assert property (@(posedge jtag_TCK) disable iff (!nrst_i)
        req_valid_i |=> !req_valid_i)
        else $error("DM request valid held for more than one cycle");

    no_second_request: assert property (@(posedge jtag_TCK) disable iff (!nrst_i)
        outstanding_q |-> !req_valid_i)
        else $error("new DM request issued before the response");

    // TDO follows the previous state, which is what the strobes show at the rising edge
    tdo_quiet: assert property (@(posedge jtag_TCK) disable iff (!nrst_i)
        !(shift_dr_i || shift_ir_i) |-> !tdo_i)
        else $error("TDO high outside the shift states");

endmodule

bind dtm_jtag_top dtm_jtag_sva dtm_jtag_sva_i (
    .jtag_TCK     (jtag_TCK),
    .nrst_i       (nrst_i),
    .shift_dr_i   (tap_ctrl.shift_dr),
    .shift_ir_i   (tap_ctrl.shift_ir),
    .tdo_i        (jtag_tdo_o),
    .req_valid_i  (dtm_req_valid_o),
    .resp_valid_i (dm_resp_valid_i)
);

//--- hdl/dtm_jtag_top.sv
/*
 * RISC-V debug transport module over JTAG
 * TAP controller, data register shifter and DMI bridge towards the DM
 */
`timescale 1ns/1ps

module dtm_jtag_top #(
    parameter dtm_pkg::dtm_reg_t IDCODE    = 32'h1E200A6F,
    parameter logic [2:0]        IDLE_HINT = 3'd5
) (
    // JTAG pins
    input  logic                jtag_TCK,
    input  logic                nrst_i,
    input  logic                jtag_tdi_i,
    input  logic                jtag_tms_i,
    output logic                jtag_tdo_o,
    // request to the DM
    output logic                dtm_req_valid_o,
    output dtm_pkg::dmi_word_t  dtm_req_data_o,
    input  logic                dm_req_ack_i,
    // response from the DM
    input  logic                dm_resp_valid_i,
    input  dtm_pkg::dmi_word_t  dm_resp_data_i,
    output logic                dtm_resp_ack_o
);

    dtm_pkg::dmi_word_t dr_value;
    dtm_pkg::dmi_word_t capture_word;
    dtm_pkg::dmi_op_t   dmi_stat;
    dtm_pkg::ir_t       ir_shift;

    // strobes and selects from the TAP
    tap_ctrl_if tap_ctrl ();

    tap_controller tap_controller_i (
        .jtag_TCK   (jtag_TCK),
        .nrst_i     (nrst_i),
        .jtag_tms_i (jtag_tms_i),
        .ctrl_if    (tap_ctrl),
        .ir_shift_i (ir_shift)
    );

    dr_shifter #(
        .IDCODE    (IDCODE),
        .IDLE_HINT (IDLE_HINT)
    ) dr_shifter_i (
        .jtag_TCK       (jtag_TCK),
        .nrst_i         (nrst_i),
        .jtag_tdi_i     (jtag_tdi_i),
        .ctrl_if        (tap_ctrl),
        .capture_word_i (capture_word),
        .dmi_stat_i     (dmi_stat),
        .dr_value_o     (dr_value),
        .ir_shift_o     (ir_shift),
        .jtag_tdo_o     (jtag_tdo_o)
    );

    dmi_bridge dmi_bridge_i (
        .jtag_TCK        (jtag_TCK),
        .nrst_i          (nrst_i),
        .ctrl_if         (tap_ctrl),
        .dr_value_i      (dr_value),
        .capture_word_o  (capture_word),
        .dmi_stat_o      (dmi_stat),
        .dm_req_ack_i    (dm_req_ack_i),
        .dtm_req_valid_o (dtm_req_valid_o),
        .dtm_req_data_o  (dtm_req_data_o),
        .dm_resp_valid_i (dm_resp_valid_i),
        .dm_resp_data_i  (dm_resp_data_i),
        .dtm_resp_ack_o  (dtm_resp_ack_o)
    );

endmodule

//--- dmi/dmi_bridge.sv
/*
 * DMI bridge
 * turns completed DMI scans into DM requests, tracks busy and sticky busy,
 * latches DM responses for the next DMI capture
 */
`timescale 1ns/1ps

module dmi_bridge (
    input  logic                jtag_TCK,
    input  logic                nrst_i,
    tap_ctrl_if.user            ctrl_if,
    // value shifted in by the debugger
    input  dtm_pkg::dmi_word_t  dr_value_i,
    output dtm_pkg::dmi_word_t  capture_word_o,
    output dtm_pkg::dmi_op_t    dmi_stat_o,
    // request side
    input  logic                dm_req_ack_i,
    output logic                dtm_req_valid_o,
    output dtm_pkg::dmi_word_t  dtm_req_data_o,
    // response side
    input  logic                dm_resp_valid_i,
    input  dtm_pkg::dmi_word_t  dm_resp_data_i,
    output logic                dtm_resp_ack_o
);

    // zero address and data, busy op
    localparam dtm_pkg::dmi_word_t BUSY_WORD = {
        {(dtm_pkg::DMI_ADDR_W + dtm_pkg::DMI_DATA_W){1'b0}},
        dtm_pkg::DMI_OP_BUSY
    };

    logic               req_valid_q;
    dtm_pkg::dmi_word_t req_data_q;
    logic               busy_q;
    logic               sticky_q;
    dtm_pkg::dmi_word_t resp_q;
    logic               is_busy;
    logic               issue;

    // either a request in flight or an unacknowledged busy report
    assign is_busy = busy_q | sticky_q;

    // ==================================================
    // request issue
    // ==================================================
    // one shot on the edge leaving update-dr, refused requests are dropped
    assign issue = ctrl_if.update_dr && ctrl_if.sel_dmi && !is_busy && !req_valid_q
                   && dm_req_ack_i;

    always_ff @(posedge jtag_TCK or negedge nrst_i) begin
        if (!nrst_i) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= issue;
        end
    end

    // request payload
    always_ff @(posedge jtag_TCK) begin
        if (issue) begin
            req_data_q <= dr_value_i;
        end
    end

    // ==================================================
    // busy tracking
    // ==================================================
    always_ff @(posedge jtag_TCK or negedge nrst_i) begin
        if (!nrst_i) begin
            busy_q <= 1'b0;
        end else if (dm_resp_valid_i) begin
            // response ends the outstanding request
            busy_q <= 1'b0;
        end else if (req_valid_q) begin
            busy_q <= 1'b1;
        end
    end

    // sticky busy, set when a dmi capture sees busy, cleared by dmireset
    always_ff @(posedge jtag_TCK or negedge nrst_i) begin
        if (!nrst_i) begin
            sticky_q <= 1'b0;
        end else if (ctrl_if.capture_dr && ctrl_if.sel_dmi) begin
            sticky_q <= is_busy;
        end else if (ctrl_if.update_dr && ctrl_if.sel_dtmcs
                     && dr_value_i[dtm_pkg::DTMCS_DMIRESET_BIT]) begin
            sticky_q <= 1'b0;
        end
    end

    // ==================================================
    // response latch
    // ==================================================
    always_ff @(posedge jtag_TCK or negedge nrst_i) begin
        if (!nrst_i) begin
            resp_q <= '0;
        end else if (dm_resp_valid_i) begin
            resp_q <= dm_resp_data_i;
        end
    end

    // every valid response is taken at once
    assign dtm_resp_ack_o = dm_resp_valid_i;

    assign capture_word_o = is_busy ? BUSY_WORD : resp_q;
    assign dmi_stat_o     = is_busy ? dtm_pkg::DMI_OP_BUSY : dtm_pkg::DMI_OP_NOP;

    assign dtm_req_valid_o = req_valid_q;
    assign dtm_req_data_o  = req_data_q;

endmodule

//--- hdl/dr_shifter.sv
/*
 * JTAG data register shifter
 * capture and shift of IR, BYPASS, IDCODE, DTMCS and DMI, plus TDO
 */
`timescale 1ns/1ps

module dr_shifter #(
    parameter dtm_pkg::dtm_reg_t IDCODE    = 32'h1E200A6F,
    parameter logic [2:0]        IDLE_HINT = 3'd5
) (
    input  logic                jtag_TCK,
    input  logic                nrst_i,
    input  logic                jtag_tdi_i,
    tap_ctrl_if.user            ctrl_if,
    // dmi word to load on capture, busy word or latched response
    input  dtm_pkg::dmi_word_t  capture_word_i,
    input  dtm_pkg::dmi_op_t    dmi_stat_i,
    output dtm_pkg::dmi_word_t  dr_value_o,
    output dtm_pkg::ir_t        ir_shift_o,
    output logic                jtag_tdo_o
);

    localparam int WORD_W = dtm_pkg::DMI_WORD_W;
    localparam int REG_W  = dtm_pkg::DTM_REG_W;
    localparam int IR_W   = dtm_pkg::IR_W;
    // zero pad above a 32-bit register
    localparam int PAD_W  = WORD_W - REG_W;
    // abits field is 6 bits wide
    localparam logic [5:0] ABITS = 6'(dtm_pkg::DMI_ADDR_W);

    dtm_pkg::dmi_word_t shift_q;
    dtm_pkg::dtm_reg_t  dtmcs;
    logic               tdo_q;

    // ==================================================
    // dtmcs layout
    // ==================================================
    // {0[31:18], dmihardreset, dmireset, 0, idle, dmistat, abits, version}
    // dmihardreset and dmireset always read as zero
    assign dtmcs = {
        14'b0,
        1'b0,
        1'b0,
        1'b0,
        IDLE_HINT,
        dmi_stat_i,
        ABITS,
        dtm_pkg::DTM_VERSION
    };

    // ==================================================
    // capture and shift, rising edge
    // ==================================================
    always_ff @(posedge jtag_TCK) begin
        if (ctrl_if.capture_ir) begin
            // IR capture pattern is 01
            shift_q <= {{(WORD_W-2){1'b0}}, 2'b01};
        end else if (ctrl_if.shift_ir) begin
            // 5-bit IR path
            shift_q <= {{(WORD_W-IR_W){1'b0}}, jtag_tdi_i, shift_q[IR_W-1:1]};
        end else if (ctrl_if.capture_dr) begin
            if (ctrl_if.sel_dmi) begin
                shift_q <= capture_word_i;
            end else if (ctrl_if.sel_dtmcs) begin
                shift_q <= {{PAD_W{1'b0}}, dtmcs};
            end else if (ctrl_if.sel_idcode) begin
                shift_q <= {{PAD_W{1'b0}}, IDCODE};
            end else begin
                // bypass captures 0
                shift_q <= '0;
            end
        end else if (ctrl_if.shift_dr) begin
            if (ctrl_if.sel_dmi) begin
                // full 39-bit dmi word
                shift_q <= {jtag_tdi_i, shift_q[WORD_W-1:1]};
            end else if (ctrl_if.sel_dtmcs || ctrl_if.sel_idcode) begin
                // 32-bit registers
                shift_q <= {{PAD_W{1'b0}}, jtag_tdi_i, shift_q[REG_W-1:1]};
            end else begin
                // single bypass bit
                shift_q <= {{(WORD_W-1){1'b0}}, jtag_tdi_i};
            end
        end
    end

    // ==================================================
    // TDO, falling edge
    // ==================================================
    always_ff @(negedge jtag_TCK or negedge nrst_i) begin
        if (!nrst_i) begin
            tdo_q <= 1'b0;
        end else if (ctrl_if.shift_ir || ctrl_if.shift_dr) begin
            tdo_q <= shift_q[0];
        end else begin
            // quiet outside the shift states
            tdo_q <= 1'b0;
        end
    end

    assign jtag_tdo_o = tdo_q;

    // shifted value goes to the DMI bridge and the IR
    assign dr_value_o = shift_q;
    assign ir_shift_o = shift_q[IR_W-1:0];

endmodule

//--- tap/tap_controller.sv
/*
 * JTAG TAP controller
 * 16-state TMS driven FSM, 5-bit instruction register and instruction decode
 */
`timescale 1ns/1ps

module tap_controller (
    input  logic             jtag_TCK,
    input  logic             nrst_i,
    input  logic             jtag_tms_i,
    tap_ctrl_if.ctrl         ctrl_if,
    // IR bits of the shift register
    input  dtm_pkg::ir_t     ir_shift_i
);

    dtm_pkg::tap_state_e state_q;
    dtm_pkg::tap_state_e state_d;
    dtm_pkg::ir_t        ir_q;

    // ==================================================
    // TAP state machine
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            dtm_pkg::TAP_RESET:
                state_d = jtag_tms_i ? dtm_pkg::TAP_RESET : dtm_pkg::TAP_IDLE;
            dtm_pkg::TAP_IDLE:
                state_d = jtag_tms_i ? dtm_pkg::TAP_SEL_DR : dtm_pkg::TAP_IDLE;
            dtm_pkg::TAP_SEL_DR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_SEL_IR : dtm_pkg::TAP_CAPTURE_DR;
            dtm_pkg::TAP_CAPTURE_DR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_EXIT1_DR : dtm_pkg::TAP_SHIFT_DR;
            dtm_pkg::TAP_SHIFT_DR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_EXIT1_DR : dtm_pkg::TAP_SHIFT_DR;
            dtm_pkg::TAP_EXIT1_DR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_UPDATE_DR : dtm_pkg::TAP_PAUSE_DR;
            dtm_pkg::TAP_PAUSE_DR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_EXIT2_DR : dtm_pkg::TAP_PAUSE_DR;
            dtm_pkg::TAP_EXIT2_DR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_UPDATE_DR : dtm_pkg::TAP_SHIFT_DR;
            dtm_pkg::TAP_UPDATE_DR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_SEL_DR : dtm_pkg::TAP_IDLE;
            // five TMS-high clocks from anywhere end up here
            dtm_pkg::TAP_SEL_IR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_RESET : dtm_pkg::TAP_CAPTURE_IR;
            dtm_pkg::TAP_CAPTURE_IR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_EXIT1_IR : dtm_pkg::TAP_SHIFT_IR;
            dtm_pkg::TAP_SHIFT_IR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_EXIT1_IR : dtm_pkg::TAP_SHIFT_IR;
            dtm_pkg::TAP_EXIT1_IR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_UPDATE_IR : dtm_pkg::TAP_PAUSE_IR;
            dtm_pkg::TAP_PAUSE_IR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_EXIT2_IR : dtm_pkg::TAP_PAUSE_IR;
            dtm_pkg::TAP_EXIT2_IR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_UPDATE_IR : dtm_pkg::TAP_SHIFT_IR;
            dtm_pkg::TAP_UPDATE_IR:
                state_d = jtag_tms_i ? dtm_pkg::TAP_SEL_DR : dtm_pkg::TAP_IDLE;
            default:
                state_d = dtm_pkg::TAP_RESET;
        endcase
    end

    always_ff @(posedge jtag_TCK or negedge nrst_i) begin
        if (!nrst_i) begin
            state_q <= dtm_pkg::TAP_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================================================
    // instruction register, falling edge
    // ==================================================
    always_ff @(negedge jtag_TCK or negedge nrst_i) begin
        if (!nrst_i) begin
            ir_q <= dtm_pkg::IR_IDCODE;
        end else if (state_q == dtm_pkg::TAP_RESET) begin
            ir_q <= dtm_pkg::IR_IDCODE;
        end else if (state_q == dtm_pkg::TAP_UPDATE_IR) begin
            // all-zero code is treated as bypass
            ir_q <= (ir_shift_i == '0) ? dtm_pkg::IR_BYPASS : ir_shift_i;
        end
    end

    // phase strobes straight from the state
    assign ctrl_if.capture_dr = (state_q == dtm_pkg::TAP_CAPTURE_DR);
    assign ctrl_if.shift_dr   = (state_q == dtm_pkg::TAP_SHIFT_DR);
    assign ctrl_if.update_dr  = (state_q == dtm_pkg::TAP_UPDATE_DR);
    assign ctrl_if.capture_ir = (state_q == dtm_pkg::TAP_CAPTURE_IR);
    assign ctrl_if.shift_ir   = (state_q == dtm_pkg::TAP_SHIFT_IR);

    // unimplemented codes decode to nothing, i.e. bypass
    assign ctrl_if.sel_idcode = (ir_q == dtm_pkg::IR_IDCODE);
    assign ctrl_if.sel_dtmcs  = (ir_q == dtm_pkg::IR_DTMCS);
    assign ctrl_if.sel_dmi    = (ir_q == dtm_pkg::IR_DMI);

endmodule

//--- common/tap_ctrl_if.sv
/*
 * TAP control bundle
 * phase strobes and decoded instruction selects from the TAP controller
 */
`timescale 1ns/1ps

interface tap_ctrl_if;

    // phase strobes, high while the TAP sits in that state
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;

    // instruction selects, none set means bypass
    logic sel_idcode;
    logic sel_dtmcs;
    logic sel_dmi;

    // driven by the TAP controller
    modport ctrl (
        output capture_dr, shift_dr, update_dr, capture_ir, shift_ir,
        output sel_idcode, sel_dtmcs, sel_dmi
    );

    // read by the data register and DMI blocks
    modport user (
        input capture_dr, shift_dr, update_dr, capture_ir, shift_ir,
        input sel_idcode, sel_dtmcs, sel_dmi
    );

endinterface

//--- common/dtm_pkg.sv
/*
 * debug transport module shared definitions
 * widths, DMI word layout, TAP states and JTAG instruction codes
 */
package dtm_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int IR_W       = 5;
    localparam int DMI_ADDR_W = 5;
    localparam int DMI_DATA_W = 32;
    localparam int DMI_OP_W   = 2;
    // full dmi scan length, address on top, op at the bottom
    localparam int DMI_WORD_W = DMI_ADDR_W + DMI_DATA_W + DMI_OP_W;
    // idcode and dtmcs length
    localparam int DTM_REG_W  = 32;

    // ==================================================
    // types
    // ==================================================
    typedef logic [IR_W-1:0]       ir_t;
    typedef logic [DMI_ADDR_W-1:0] dmi_addr_t;
    typedef logic [DMI_DATA_W-1:0] dmi_data_t;
    typedef logic [DMI_OP_W-1:0]   dmi_op_t;
    // {address, data, op}
    typedef logic [DMI_WORD_W-1:0] dmi_word_t;
    typedef logic [DTM_REG_W-1:0]  dtm_reg_t;

    // 16 TAP controller states, encoding follows IEEE 1149.1 order used by the team
    typedef enum logic [3:0] {
        TAP_RESET      = 4'd0,
        TAP_IDLE       = 4'd1,
        TAP_SEL_DR     = 4'd2,
        TAP_CAPTURE_DR = 4'd3,
        TAP_SHIFT_DR   = 4'd4,
        TAP_EXIT1_DR   = 4'd5,
        TAP_PAUSE_DR   = 4'd6,
        TAP_EXIT2_DR   = 4'd7,
        TAP_UPDATE_DR  = 4'd8,
        TAP_SEL_IR     = 4'd9,
        TAP_CAPTURE_IR = 4'd10,
        TAP_SHIFT_IR   = 4'd11,
        TAP_EXIT1_IR   = 4'd12,
        TAP_PAUSE_IR   = 4'd13,
        TAP_EXIT2_IR   = 4'd14,
        TAP_UPDATE_IR  = 4'd15
    } tap_state_e;

    // ==================================================
    // instruction codes and field values
    // ==================================================
    localparam ir_t IR_BYPASS = 5'h1f;
    localparam ir_t IR_IDCODE = 5'h01;
    localparam ir_t IR_DTMCS  = 5'h10;
    localparam ir_t IR_DMI    = 5'h11;

    // op as written by the debugger / status as read back
    localparam dmi_op_t DMI_OP_NOP   = 2'd0;
    localparam dmi_op_t DMI_OP_READ  = 2'd1;
    localparam dmi_op_t DMI_OP_WRITE = 2'd2;
    localparam dmi_op_t DMI_OP_BUSY  = 2'd3;

    // debug spec 0.13
    localparam logic [3:0] DTM_VERSION = 4'h1;
    // writing 1 here clears sticky busy
    localparam int DTMCS_DMIRESET_BIT = 16;

endpackage
